// File: Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tbImageResizer -Mdir obj_dir
	./obj_dir/VtbImageResizer | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: bench/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

    ////////////////////////////////////////////////////////////
    // sampling grid, output index k counted from 1
    // position is size*k/D, near is its integer part plus one

    function automatic int gridNear(input int size, input int k);
        int n;
        n = (size * k) / resizePkg::OUT_DIM + 1;
        return (n > size) ? size : n;          // clamp at last column
    endfunction

    function automatic int gridFar(input int size, input int k);
        int f;
        f = gridNear(size, k) + 1;
        return (f > size) ? size : f;
    endfunction

    function automatic int gridDelta(input int size, input int k);
        return (size * k) % resizePkg::OUT_DIM;   // fraction in 1/D steps
    endfunction

    ////////////////////////////////////////////////////////////
    // bilinear blend of one output point from the stored frame
    function automatic resizePkg::pixelT expectedPixel(input int width, input int height,
                                                       input int outRow, input int outCol);
        int               nc;
        int               fc;
        int               nr;
        int               fr;
        int               dh;
        int               dv;
        int               sum;
        int               w [4];
        resizePkg::pixelT p [4];
        resizePkg::pixelT res;
        nc = gridNear(width, outCol + 1);
        fc = gridFar(width, outCol + 1);
        dh = gridDelta(width, outCol + 1);
        nr = gridNear(height, outRow + 1);
        fr = gridFar(height, outRow + 1);
        dv = gridDelta(height, outRow + 1);
        p[0] = frameMem[nr * 256 + nc];        // col near, row near
        p[1] = frameMem[fr * 256 + nc];        // col near, row far
        p[2] = frameMem[nr * 256 + fc];
        p[3] = frameMem[fr * 256 + fc];
        w[0] = (resizePkg::OUT_DIM - dh) * (resizePkg::OUT_DIM - dv);
        w[1] = (resizePkg::OUT_DIM - dh) * dv;
        w[2] = dh * (resizePkg::OUT_DIM - dv);
        w[3] = dh * dv;
        res = '0;
        for (int c = 0; c < 3; c++)
        begin
            sum = 0;
            for (int m = 0; m < 4; m++)
                sum += int'(p[m][c*8 +: 8]) * w[m];
            res[c*8 +: 8] = 8'(sum / (resizePkg::OUT_DIM * resizePkg::OUT_DIM));  // floor
        end
        return res;
    endfunction

`endif

// File: bench/tbImageResizer.sv
`timescale 1ns/1ps

module tbImageResizer;

    localparam int FRAMES     = 5;
    localparam int FLAT_FRAME = 2;        // single colour frame
    localparam int WAIT_LIMIT = 200;      // cycles allowed per wait

    logic             clk_in = 1'b0;
    logic             arstN;
    resizePkg::sizeT  sizeIn;
    logic             sizeValid;
    resizePkg::pixelT pixelIn;
    logic             pixelValid;
    logic             ready;
    resizePkg::pixelT pixelOut;
    logic             outValid;
    logic             frameDone;

    resizePkg::pixelT frameMem [0:65535];  // input frame at {row, col}
    logic [15:0]      lfsr = 16'd36303;
    int               pixelErrors = 0;
    int               flagErrors  = 0;
    int               otherErrors = 0;
    bit               aborted     = 1'b0;  // set on any timeout

    `include "tbModel.svh"

    imageResizer u_imageResizer (
        .clk_in     (clk_in),
        .arstN      (arstN),
        .sizeIn     (sizeIn),
        .sizeValid  (sizeValid),
        .pixelIn    (pixelIn),
        .pixelValid (pixelValid),
        .ready      (ready),
        .pixelOut   (pixelOut),
        .outValid   (outValid),
        .frameDone  (frameDone)
    );

    always #4 clk_in = ~clk_in;          // 8 ns period

    ////////////////////////////////////////////////////////////
    // galois lfsr, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic stepCycle();
        @(posedge clk_in);
        #1;                              // drive and sample away from the edge
    endtask

    task automatic checkPixel(input string name, input resizePkg::pixelT got,
                              input resizePkg::pixelT exp);
        if (got !== exp)
        begin
            pixelErrors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            flagErrors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic waitForReady();
        int count;
        count = 0;
        while (ready !== 1'b1 && count < WAIT_LIMIT)
        begin
            stepCycle();
            count++;
        end
        if (ready !== 1'b1)
        begin
            otherErrors++;
            aborted = 1'b1;
            $display("timeout: ready did not return high within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic waitForOutput();
        int count;
        count = 0;
        while (outValid !== 1'b1 && count < WAIT_LIMIT)
        begin
            stepCycle();
            count++;
        end
        if (outValid !== 1'b1)
        begin
            otherErrors++;
            aborted = 1'b1;
            $display("timeout: no output pixel within %0d cycles of the frame end", WAIT_LIMIT);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one frame: size strobe, ignored strobe, raster in, raster out
    task automatic runFrame(input int frameNo);
        int               width;
        int               height;
        bit               flat;
        resizePkg::pixelT colour;
        resizePkg::pixelT exp;
        width  = 16 + int'(randBits(6)) % 49;
        height = 16 + int'(randBits(6)) % 49;
        flat   = (frameNo == FLAT_FRAME);
        colour = 24'(randBits(24));
        waitForReady();
        if (aborted)
            return;
        sizeIn.width  = 8'(width);
        sizeIn.height = 8'(height);
        sizeValid     = 1'b1;
        stepCycle();
        sizeValid = 1'b0;
        checkFlag("ready", ready, 1'b0);   // busy after accept
        for (int i = 1; i < resizePkg::OUT_DIM + 4; i++)
        begin
            if (i == 3)
            begin
                // other sizes while busy, must be dropped
                sizeIn.width  = 8'(16 + (width - 15 + int'(randBits(5))) % 49);
                sizeIn.height = 8'(16 + (height - 15 + int'(randBits(5))) % 49);
                sizeValid     = 1'b1;
            end
            else
                sizeValid = 1'b0;
            stepCycle();
        end
        checkFlag("ready", ready, 1'b0);
        for (int r = 1; r <= height; r++)
        begin
            for (int c = 1; c <= width; c++)
            begin
                if (randBits(2) == 0)        // one idle cycle
                begin
                    pixelValid = 1'b0;
                    stepCycle();
                end
                pixelIn    = flat ? colour : 24'(randBits(24));
                pixelValid = 1'b1;
                frameMem[r * 256 + c] = pixelIn;
                stepCycle();
            end
        end
        pixelValid = 1'b0;
        waitForOutput();
        if (aborted)
            return;
        for (int p = 0; p < resizePkg::OUT_DIM * resizePkg::OUT_DIM; p++)
        begin
            exp = flat ? colour
                       : expectedPixel(width, height, p / resizePkg::OUT_DIM,
                                       p % resizePkg::OUT_DIM);
            checkFlag("outValid", outValid, 1'b1);
            checkFlag("frameDone", frameDone, 1'b0);
            checkPixel($sformatf("pixelOut[%0d]", p), pixelOut, exp);
            stepCycle();
        end
        checkFlag("outValid", outValid, 1'b0);
        checkFlag("frameDone", frameDone, 1'b1);   // right after last point
        checkFlag("ready", ready, 1'b0);
        stepCycle();
        checkFlag("frameDone", frameDone, 1'b0);
        checkFlag("ready", ready, 1'b1);
    endtask

    initial
    begin
        arstN      = 1'b0;
        sizeIn     = '0;
        sizeValid  = 1'b0;
        pixelIn    = '0;
        pixelValid = 1'b0;
        repeat (3) @(posedge clk_in);
        #1;
        arstN = 1'b1;
        checkFlag("ready", ready, 1'b1);
        checkFlag("outValid", outValid, 1'b0);
        checkFlag("frameDone", frameDone, 1'b0);
        for (int f = 0; f < FRAMES && !aborted; f++)
            runFrame(f);
        $display("errors: pixel %0d, flag %0d, other %0d",
                 pixelErrors, flagErrors, otherErrors);
        if (pixelErrors + flagErrors + otherErrors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: blend/bilinearBlend.sv
`timescale 1ns/1ps

module bilinearBlend (
    input  logic                             clk_in,
    input  logic                             arstN,
    input  logic                             captureDone,
    input  resizePkg::gridEntryT             colEntry,
    input  resizePkg::gridEntryT             rowEntry,
    output logic [resizePkg::IDX_BITS-1:0]   colIdx,
    output logic [resizePkg::IDX_BITS-1:0]   rowIdx,
    output logic [resizePkg::ADDR_BITS-1:0]  rdAddr,
    input  resizePkg::pixelT                 ctxData [4],
    output resizePkg::pixelT                 pixelOut,
    output logic                             outValid,
    output logic                             frameDone
);

    logic                               running;
    logic [resizePkg::IDX_BITS-1:0]     colCnt;
    logic [resizePkg::IDX_BITS-1:0]     rowCnt;
    logic                               colLast;
    logic [3:0]                         validPipe;   // read, weight, product, sum
    logic [resizePkg::FRAC_BITS:0]      dh;          // 0..D
    logic [resizePkg::FRAC_BITS:0]      dv;
    logic [resizePkg::FRAC_BITS:0]      dhQ;
    logic [resizePkg::FRAC_BITS:0]      dvQ;
    logic [resizePkg::FRAC_BITS:0]      omh;         // D - dh
    logic [resizePkg::FRAC_BITS:0]      omv;
    logic [3:0][resizePkg::WEIGHT_BITS-1:0]      weightQ;
    resizePkg::pixelT [3:0]                      dataQ;
    logic [3:0][2:0][resizePkg::WEIGHT_BITS+7:0] prodQ;    // [memory][channel]
    logic [2:0][resizePkg::WEIGHT_BITS+9:0]      chanSum;

    ////////////////////////////////////////////////////////////
    // output raster
    assign colLast = (colCnt == resizePkg::IDX_BITS'(resizePkg::OUT_DIM - 1));
    assign colIdx  = colCnt;
    assign rowIdx  = rowCnt;
    assign rdAddr  = {rowCnt, colCnt};

    always_ff @(posedge clk_in or negedge arstN)
    begin
        if (!arstN)
        begin
            running   <= 1'b0;
            colCnt    <= '0;
            rowCnt    <= '0;
            validPipe <= '0;
            frameDone <= 1'b0;
        end
        else
        begin
            if (captureDone)
            begin
                running <= 1'b1;
                colCnt  <= '0;
                rowCnt  <= '0;
            end
            else if (running)
            begin
                colCnt <= colCnt + 1'b1;
                if (colLast)
                begin
                    rowCnt <= rowCnt + 1'b1;
                    if (rowCnt == resizePkg::IDX_BITS'(resizePkg::OUT_DIM - 1))
                        running <= 1'b0;       // last point read
                end
            end
            validPipe <= {validPipe[2:0], running};
            frameDone <= validPipe[3] & ~validPipe[2];   // right after last outValid
        end
    end

    assign outValid = validPipe[3];

    ////////////////////////////////////////////////////////////
    // weights, a far-only entry puts the full weight on far
    assign dh  = (colEntry.near == '0) ? (resizePkg::FRAC_BITS+1)'(resizePkg::OUT_DIM)
                                       : {1'b0, colEntry.delta};
    assign dv  = (rowEntry.near == '0) ? (resizePkg::FRAC_BITS+1)'(resizePkg::OUT_DIM)
                                       : {1'b0, rowEntry.delta};
    assign omh = (resizePkg::FRAC_BITS+1)'(resizePkg::OUT_DIM) - dhQ;
    assign omv = (resizePkg::FRAC_BITS+1)'(resizePkg::OUT_DIM) - dvQ;

    always_comb
    begin
        for (int c = 0; c < 3; c++)
            chanSum[c] = prodQ[0][c] + prodQ[1][c] + prodQ[2][c] + prodQ[3][c];
    end

    always_ff @(posedge clk_in)
    begin
        dhQ <= dh;                     // stage 1 beside memory read
        dvQ <= dv;
        weightQ[0] <= omh * omv;       // stage 2, weights sum to D*D
        weightQ[1] <= omh * dvQ;
        weightQ[2] <= dhQ * omv;
        weightQ[3] <= dhQ * dvQ;
        for (int m = 0; m < 4; m++)
            dataQ[m] <= ctxData[m];
        for (int m = 0; m < 4; m++)    // stage 3
        begin
            for (int c = 0; c < 3; c++)
            begin
                // zero weight also masks points never written this frame
                prodQ[m][c] <= (weightQ[m] == '0) ? '0 : dataQ[m][c*8 +: 8] * weightQ[m];
            end
        end
        for (int c = 0; c < 3; c++)    // stage 4, divide by D*D
            pixelOut[c*8 +: 8] <= chanSum[c][2*resizePkg::FRAC_BITS +: 8];
    end

    // memories must not be refilled under a running readout
    assert property (@(posedge clk_in) disable iff (!arstN)
        captureDone |-> !running && validPipe == '0);

endmodule

// File: capture/contextRam.sv
`timescale 1ns/1ps

module contextRam #(
    parameter logic [1:0] memSel = 2'd0    // {col role, row role}
) (
    input  logic                            clk_in,
    input  resizePkg::ctxWriteT             ctxWrite,
    input  logic [resizePkg::ADDR_BITS-1:0] rdAddr,
    output resizePkg::pixelT                rdData
);

    resizePkg::pixelT mem [0:(1 << resizePkg::ADDR_BITS) - 1];   // one pixel per point

    always_ff @(posedge clk_in)
    begin
        if (ctxWrite.we[memSel])
            mem[ctxWrite.addr[memSel]] <= ctxWrite.pixel;
        rdData <= mem[rdAddr];      // registered read
    end

endmodule

// File: capture/neighborCapture.sv
`timescale 1ns/1ps

module neighborCapture (
    input  logic                 clk_in,
    input  logic                 arstN,
    input  resizePkg::sizeT      frameSize,
    input  resizePkg::gridEntryT colTable [resizePkg::OUT_DIM],
    input  resizePkg::gridEntryT rowTable [resizePkg::OUT_DIM],
    input  resizePkg::pixelT     pixelIn,
    input  logic                 pixelValid,
    output resizePkg::ctxWriteT  ctxWrite,
    output logic                 captureDone
);

    logic [resizePkg::COORD_BITS-1:0]   colCnt;    // column of next pixel, from 1
    logic [resizePkg::COORD_BITS-1:0]   rowCnt;
    logic                               lastPixel;
    logic [1:0][resizePkg::OUT_DIM-1:0] colHit;    // [0] near role, [1] far role
    logic [1:0][resizePkg::OUT_DIM-1:0] rowHit;
    logic [1:0][resizePkg::OUT_DIM-1:0] colHitQ;
    logic [1:0][resizePkg::OUT_DIM-1:0] rowHitQ;
    resizePkg::pixelT                   pixelQ;
    logic                               validQ;
    logic                               lastQ;
    logic [3:0]                         weQ;
    logic [3:0][resizePkg::ADDR_BITS-1:0] addrQ;
    resizePkg::pixelT                   dataQ;

    // one-hot to index, hits are never more than one
    function automatic logic [resizePkg::IDX_BITS-1:0] encode(
        input logic [resizePkg::OUT_DIM-1:0] hot);
        logic [resizePkg::IDX_BITS-1:0] idx;
        idx = '0;
        for (int j = 0; j < resizePkg::OUT_DIM; j++)
        begin
            if (hot[j])
                idx = idx | resizePkg::IDX_BITS'(j);
        end
        return idx;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare raster position with every grid entry
    always_comb
    begin
        for (int j = 0; j < resizePkg::OUT_DIM; j++)
        begin
            colHit[0][j] = (colCnt == colTable[j].near);
            // far only matters with nonzero delta or a far-only entry
            colHit[1][j] = (colCnt == colTable[j].far)
                           && (colTable[j].delta != '0 || colTable[j].near == '0);
            rowHit[0][j] = (rowCnt == rowTable[j].near);
            rowHit[1][j] = (rowCnt == rowTable[j].far)
                           && (rowTable[j].delta != '0 || rowTable[j].near == '0);
        end
    end

    assign lastPixel = pixelValid && colCnt == frameSize.width
                       && rowCnt == frameSize.height;

    always_ff @(posedge clk_in or negedge arstN)
    begin
        if (!arstN)
        begin
            colCnt      <= resizePkg::COORD_BITS'(1);
            rowCnt      <= resizePkg::COORD_BITS'(1);
            validQ      <= 1'b0;
            lastQ       <= 1'b0;
            weQ         <= '0;
            captureDone <= 1'b0;
        end
        else
        begin
            if (pixelValid)
            begin
                if (colCnt == frameSize.width)
                begin
                    colCnt <= resizePkg::COORD_BITS'(1);   // next line
                    rowCnt <= lastPixel ? resizePkg::COORD_BITS'(1) : rowCnt + 1'b1;
                end
                else
                    colCnt <= colCnt + 1'b1;
            end
            validQ      <= pixelValid;                     // compare stage
            lastQ       <= lastPixel;
            captureDone <= lastQ;                          // write stage
            for (int m = 0; m < 4; m++)
                weQ[m] <= validQ && (|colHitQ[m / 2]) && (|rowHitQ[m % 2]);
        end
    end

    always_ff @(posedge clk_in)
    begin
        colHitQ <= colHit;
        rowHitQ <= rowHit;
        pixelQ  <= pixelIn;
        dataQ   <= pixelQ;
        for (int m = 0; m < 4; m++)
            addrQ[m] <= {encode(rowHitQ[m % 2]), encode(colHitQ[m / 2])};  // {row, col}
    end

    assign ctxWrite = '{we: weQ, addr: addrQ, pixel: dataQ};

    // grid tables must give each pixel a single point per role
    assert property (@(posedge clk_in) disable iff (!arstN)
        pixelValid |-> $onehot0(colHit[0]) && $onehot0(colHit[1])
                       && $onehot0(rowHit[0]) && $onehot0(rowHit[1]));

endmodule

// File: common/resizePkg.sv
package resizePkg;

    ////////////////////////////////////////////////////////////
    // sizes
    localparam int OUT_DIM     = 16;                 // output side, both axes
    localparam int FRAC_BITS   = 4;                  // log2(OUT_DIM)
    localparam int COORD_BITS  = 8;                  // input coordinate, max 255
    localparam int IDX_BITS    = 4;                  // output index
    localparam int ADDR_BITS   = 8;                  // {row, col} of output point
    localparam int WEIGHT_BITS = 2 * (FRAC_BITS + 1); // product of two weights

    ////////////////////////////////////////////////////////////
    // payloads
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixelT;

    typedef struct packed {
        logic [COORD_BITS-1:0] width;
        logic [COORD_BITS-1:0] height;
    } sizeT;

    // near of 0 marks an entry served only by the far memories
    typedef struct packed {
        logic [COORD_BITS-1:0] near;   // first neighbour, from 1
        logic [COORD_BITS-1:0] far;    // second neighbour
        logic [FRAC_BITS-1:0]  delta;  // fraction of position
    } gridEntryT;

    // neighbour roles hit different output points, so each memory has its own address
    typedef struct packed {
        logic [3:0]                we;     // one bit per context memory
        logic [3:0][ADDR_BITS-1:0] addr;   // indexed by memory
        pixelT                     pixel;
    } ctxWriteT;

endpackage

// File: grid/gridAxis.sv
`timescale 1ns/1ps

module gridAxis (
    input  logic                            clk_in,
    input  logic                            arstN,
    input  logic [resizePkg::COORD_BITS-1:0] axisSize,
    input  logic                            gridStart,
    input  logic [resizePkg::IDX_BITS-1:0]  lookupIdx,
    output resizePkg::gridEntryT            lookupEntry,
    output resizePkg::gridEntryT            gridTable [resizePkg::OUT_DIM]
);

    logic                                          running;
    logic [resizePkg::IDX_BITS-1:0]                stepIdx;    // entry k-1
    logic [resizePkg::COORD_BITS+resizePkg::FRAC_BITS-1:0] position;  // size*k, 4 frac bits
    logic [resizePkg::COORD_BITS:0]                nearWide;   // may reach 256
    logic [resizePkg::COORD_BITS-1:0]              nearVal;
    logic [resizePkg::COORD_BITS-1:0]              farVal;
    logic                                          lastIdx;
    resizePkg::gridEntryT                          newEntry;

    assign nearWide = {1'b0, position[resizePkg::COORD_BITS+resizePkg::FRAC_BITS-1:
                                      resizePkg::FRAC_BITS]} + 1'b1;
    assign nearVal  = (nearWide > {1'b0, axisSize}) ? axisSize
                                                    : nearWide[resizePkg::COORD_BITS-1:0];
    assign farVal   = (nearVal < axisSize) ? nearVal + 1'b1 : axisSize;  // clamp at edge
    assign lastIdx  = (stepIdx == resizePkg::IDX_BITS'(resizePkg::OUT_DIM - 1));

    // last entry is always near = far = size
    // if the entry before already owns that near column, serve it from far
    always_comb
    begin
        newEntry.near  = (lastIdx && gridTable[resizePkg::OUT_DIM-2].near == axisSize)
                         ? '0 : nearVal;
        newEntry.far   = farVal;
        newEntry.delta = position[resizePkg::FRAC_BITS-1:0];
    end

    always_ff @(posedge clk_in or negedge arstN)
    begin
        if (!arstN)
        begin
            running <= 1'b0;
            stepIdx <= '0;
        end
        else if (gridStart)
        begin
            running <= 1'b1;
            stepIdx <= '0;
        end
        else if (running)
        begin
            stepIdx <= stepIdx + 1'b1;   // wraps to 0 after the last entry
            if (lastIdx)
                running <= 1'b0;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (gridStart)
            position <= {{resizePkg::FRAC_BITS{1'b0}}, axisSize};   // k = 1
        else if (running)
        begin
            position <= position + axisSize;   // accumulate, no multiplier
            gridTable[stepIdx] <= newEntry;
        end
    end

    assign lookupEntry = gridTable[lookupIdx];

endmodule

// File: source/imageResizer.sv
`timescale 1ns/1ps

module imageResizer (
    input  logic             clk_in,
    input  logic             arstN,
    input  resizePkg::sizeT  sizeIn,
    input  logic             sizeValid,
    input  resizePkg::pixelT pixelIn,
    input  logic             pixelValid,
    output logic             ready,
    output resizePkg::pixelT pixelOut,
    output logic             outValid,
    output logic             frameDone
);

    resizePkg::sizeT      frameSize;
    logic                 gridStart;
    resizePkg::gridEntryT colTable [resizePkg::OUT_DIM];   // whole tables for matching
    resizePkg::gridEntryT rowTable [resizePkg::OUT_DIM];
    resizePkg::gridEntryT colEntry;                        // single lookups for blending
    resizePkg::gridEntryT rowEntry;
    logic [resizePkg::IDX_BITS-1:0]  colIdx;
    logic [resizePkg::IDX_BITS-1:0]  rowIdx;
    logic [resizePkg::ADDR_BITS-1:0] rdAddr;
    resizePkg::ctxWriteT  ctxWrite;
    logic                 captureDone;
    resizePkg::pixelT     ctxData [4];

    ////////////////////////////////////////////////////////////
    // control and sampling grids
    resizeConfig u_resizeConfig (
        .clk_in    (clk_in),
        .arstN     (arstN),
        .sizeIn    (sizeIn),
        .sizeValid (sizeValid),
        .frameDone (frameDone),
        .frameSize (frameSize),
        .gridStart (gridStart),
        .ready     (ready)
    );

    gridAxis colGrid (
        .clk_in      (clk_in),
        .arstN       (arstN),
        .axisSize    (frameSize.width),
        .gridStart   (gridStart),
        .lookupIdx   (colIdx),
        .lookupEntry (colEntry),
        .gridTable   (colTable)
    );

    gridAxis rowGrid (
        .clk_in      (clk_in),
        .arstN       (arstN),
        .axisSize    (frameSize.height),
        .gridStart   (gridStart),
        .lookupIdx   (rowIdx),
        .lookupEntry (rowEntry),
        .gridTable   (rowTable)
    );

    ////////////////////////////////////////////////////////////
    // capture into context memories, then blend
    neighborCapture u_neighborCapture (
        .clk_in      (clk_in),
        .arstN       (arstN),
        .frameSize   (frameSize),
        .colTable    (colTable),
        .rowTable    (rowTable),
        .pixelIn     (pixelIn),
        .pixelValid  (pixelValid),
        .ctxWrite    (ctxWrite),
        .captureDone (captureDone)
    );

    for (genvar m = 0; m < 4; m++)
    begin : g_ctx
        contextRam #(.memSel(2'(m))) u_contextRam (  // m = {col role, row role}
            .clk_in   (clk_in),
            .ctxWrite (ctxWrite),
            .rdAddr   (rdAddr),
            .rdData   (ctxData[m])
        );
    end

    bilinearBlend u_bilinearBlend (
        .clk_in      (clk_in),
        .arstN       (arstN),
        .captureDone (captureDone),
        .colEntry    (colEntry),
        .rowEntry    (rowEntry),
        .colIdx      (colIdx),
        .rowIdx      (rowIdx),
        .rdAddr      (rdAddr),
        .ctxData     (ctxData),
        .pixelOut    (pixelOut),
        .outValid    (outValid),
        .frameDone   (frameDone)
    );

endmodule

// File: source/resizeConfig.sv
`timescale 1ns/1ps

module resizeConfig (
    input  logic            clk_in,
    input  logic            arstN,
    input  resizePkg::sizeT sizeIn,
    input  logic            sizeValid,
    input  logic            frameDone,
    output resizePkg::sizeT frameSize,
    output logic            gridStart,
    output logic            ready
);

    logic accept;   // strobe only counts while idle

    assign accept = sizeValid & ready;

    always_ff @(posedge clk_in or negedge arstN)
    begin
        if (!arstN)
        begin
            ready     <= 1'b1;
            gridStart <= 1'b0;
        end
        else
        begin
            gridStart <= accept;      // one pulse per frame
            if (accept)
                ready <= 1'b0;        // busy until readout ends
            else if (frameDone)
                ready <= 1'b1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept)
            frameSize <= sizeIn;      // held for the whole frame
    end

    // smaller inputs would need one pixel in several points of one memory
    assert property (@(posedge clk_in) disable iff (!arstN)
        accept |=> frameSize.width >= resizePkg::OUT_DIM
                   && frameSize.height >= resizePkg::OUT_DIM);

endmodule

// File: src.f
+incdir+bench
common/resizePkg.sv
source/resizeConfig.sv
grid/gridAxis.sv
capture/contextRam.sv
capture/neighborCapture.sv
blend/bilinearBlend.sv
source/imageResizer.sv
bench/tbImageResizer.sv
